/* hdl/mapperPkg.sv */
`default_nettype none

package mapperPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int CoordWidth   = 10;
    localparam int KeyWidth     = 16;
    localparam int KeyByteWidth = KeyWidth / 2;
    localparam int IndexWidth   = 4;
    localparam int ColorWidth   = 8;

    // keyboard usage codes, one per byte of the keycode
    localparam logic [KeyByteWidth-1:0] KeyA = 8'd4;
    localparam logic [KeyByteWidth-1:0] KeyD = 8'd7;
    localparam logic [KeyByteWidth-1:0] KeyW = 8'd26;
    localparam logic [KeyByteWidth-1:0] KeyS = 8'd22;

    // ----------------------------------------
    // screen window and map tiling
    // ----------------------------------------
    // window on screen, map shown scaled by two
    localparam int WindowW = 480;
    localparam int WindowH = 320;
    // map tiles are 16x16 map pixels
    localparam int TileShift = 4;

    // ----------------------------------------
    // sprite box and travel limits
    // ----------------------------------------
    // box spans half-1 on the right and below
    localparam logic [CoordWidth-1:0] SpriteHalfW = 10'd7;
    localparam logic [CoordWidth-1:0] SpriteHalfH = 10'd10;
    localparam logic [CoordWidth-1:0] SpriteW     = 2 * SpriteHalfW;
    localparam logic [CoordWidth-1:0] SpriteH     = 2 * SpriteHalfH;

    localparam logic [CoordWidth-1:0] SpriteXCenter = 10'd320;
    localparam logic [CoordWidth-1:0] SpriteYCenter = 10'd240;
    localparam logic [CoordWidth-1:0] SpriteXMin    = 10'd100;
    localparam logic [CoordWidth-1:0] SpriteXMax    = 10'd539;
    localparam logic [CoordWidth-1:0] SpriteYMin    = 10'd100;
    localparam logic [CoordWidth-1:0] SpriteYMax    = 10'd379;

    // fixed palette channels
    localparam logic [ColorWidth-1:0] MapBlue    = 8'd128;
    localparam logic [ColorWidth-1:0] SpriteRed  = 8'd255;
    localparam logic [ColorWidth-1:0] SpriteBlue = 8'd0;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef enum logic [1:0] {
        stepNeg,
        stepNone,
        stepPos
    } stepDir;

    typedef struct packed {
        stepDir xStep;
        stepDir yStep;
    } moveCmd;

    typedef struct packed {
        logic [CoordWidth-1:0] x;
        logic [CoordWidth-1:0] y;
    } pixelPos;

    // camera is the map coordinate of the window's top-left corner
    typedef struct packed {
        pixelPos camera;
        pixelPos sprite;
    } viewState;

    // stage one to stage two
    typedef struct packed {
        logic                  visible;
        logic [IndexWidth-1:0] mapIndex;
        logic                  spriteHit;
        logic [IndexWidth-1:0] spriteIndex;
    } fetchWord;

    typedef struct packed {
        logic [ColorWidth-1:0] red;
        logic [ColorWidth-1:0] green;
        logic [ColorWidth-1:0] blue;
    } rgbPixel;

endpackage

`default_nettype wire

/* hdl/keyDecoder.sv */
`default_nettype none

module keyDecoder (
    input  logic [mapperPkg::KeyWidth-1:0] keycode,
    output mapperPkg::moveCmd              move
);

    // one key byte to a step on its own axis
    function automatic mapperPkg::moveCmd keyStep(
        input logic [mapperPkg::KeyByteWidth-1:0] key
    );
        mapperPkg::moveCmd step;
        step.xStep = mapperPkg::stepNone;
        step.yStep = mapperPkg::stepNone;
        case (key)
            mapperPkg::KeyA: step.xStep = mapperPkg::stepNeg;
            mapperPkg::KeyD: step.xStep = mapperPkg::stepPos;
            mapperPkg::KeyW: step.yStep = mapperPkg::stepNeg;
            mapperPkg::KeyS: step.yStep = mapperPkg::stepPos;
            default: ;
        endcase
        return step;
    endfunction

    mapperPkg::moveCmd loStep;
    mapperPkg::moveCmd hiStep;
    logic loHoriz;
    logic loVert;
    logic hiHoriz;
    logic hiVert;

    assign loStep = keyStep(keycode[mapperPkg::KeyByteWidth-1:0]);
    assign hiStep = keyStep(keycode[mapperPkg::KeyWidth-1:mapperPkg::KeyByteWidth]);

    // which axis each byte asks for
    assign loHoriz = (loStep.xStep != mapperPkg::stepNone);
    assign loVert  = (loStep.yStep != mapperPkg::stepNone);
    assign hiHoriz = (hiStep.xStep != mapperPkg::stepNone);
    assign hiVert  = (hiStep.yStep != mapperPkg::stepNone);

    always_comb begin
        move.xStep = mapperPkg::stepNone;
        move.yStep = mapperPkg::stepNone;
        // single key sits in the low byte
        if (keycode[mapperPkg::KeyWidth-1:mapperPkg::KeyByteWidth] == '0) begin
            move = loStep;
        end
        // pair, one axis from each byte, either order
        else if (loHoriz && hiVert) begin
            move.xStep = loStep.xStep;
            move.yStep = hiStep.yStep;
        end
        else if (loVert && hiHoriz) begin
            move.xStep = hiStep.xStep;
            move.yStep = loStep.yStep;
        end
        // same axis twice or unknown byte falls through as no motion
    end

endmodule

`default_nettype wire

/* hdl/scrollControl.sv */
`default_nettype none

module scrollControl #(
    parameter int CameraXMax = 240,
    parameter int CameraYMax = 160
) (
    input  logic                clk,
    input  logic                Reset,
    input  logic                frameStart,
    input  mapperPkg::moveCmd   move,
    output mapperPkg::viewState view
);

    localparam int W = mapperPkg::CoordWidth;

    localparam logic [W-1:0] CamXLimit = W'(CameraXMax);
    localparam logic [W-1:0] CamYLimit = W'(CameraYMax);

    // camera at origin, sprite centred
    localparam mapperPkg::viewState ViewReset = '{
        camera: '{x: '0, y: '0},
        sprite: '{x: mapperPkg::SpriteXCenter, y: mapperPkg::SpriteYCenter}
    };

    // ----------------------------------------
    // per-axis move rule
    // ----------------------------------------
    // camera scrolls only while the sprite rests at centre
    // otherwise the sprite walks, clamped to its limits
    function automatic void stepAxis(
        input  mapperPkg::stepDir step,
        input  logic [W-1:0]      cam,
        input  logic [W-1:0]      spr,
        input  logic [W-1:0]      camMax,
        input  logic [W-1:0]      sprCenter,
        input  logic [W-1:0]      sprMin,
        input  logic [W-1:0]      sprMax,
        output logic [W-1:0]      camNext,
        output logic [W-1:0]      sprNext
    );
        logic atCenter;
        atCenter = (spr == sprCenter);
        camNext  = cam;
        sprNext  = spr;
        case (step)
            mapperPkg::stepNeg: begin
                if (atCenter && (cam != '0)) begin
                    camNext = cam - 1'b1;
                end
                else if (spr > sprMin) begin
                    sprNext = spr - 1'b1;
                end
            end
            mapperPkg::stepPos: begin
                if (atCenter && (cam < camMax)) begin
                    camNext = cam + 1'b1;
                end
                else if (spr < sprMax) begin
                    sprNext = spr + 1'b1;
                end
            end
            // stepNone holds the axis
            default: ;
        endcase
    endfunction

    mapperPkg::viewState viewNext;

    // axes are independent
    always_comb begin
        stepAxis(move.xStep, view.camera.x, view.sprite.x, CamXLimit,
                 mapperPkg::SpriteXCenter, mapperPkg::SpriteXMin, mapperPkg::SpriteXMax,
                 viewNext.camera.x, viewNext.sprite.x);
        stepAxis(move.yStep, view.camera.y, view.sprite.y, CamYLimit,
                 mapperPkg::SpriteYCenter, mapperPkg::SpriteYMin, mapperPkg::SpriteYMax,
                 viewNext.camera.y, viewNext.sprite.y);
    end

    // ----------------------------------------
    // state, one update per frame
    // ----------------------------------------
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            view <= ViewReset;
        end
        else if (frameStart) begin
            view <= viewNext;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixelFetch.sv */
`default_nettype none

module pixelFetch #(
    parameter int WindowX0 = 80,
    parameter int WindowY0 = 80
) (
    input  logic                clk,
    input  logic                Reset,
    input  mapperPkg::pixelPos  drawPos,
    input  logic                blank,
    input  mapperPkg::viewState view,
    output mapperPkg::fetchWord fetch
);

    localparam int W  = mapperPkg::CoordWidth;
    localparam int IW = mapperPkg::IndexWidth;
    localparam int TS = mapperPkg::TileShift;

    // window edges in screen pixels, right and bottom exclusive
    localparam logic [W-1:0] WinX0 = W'(WindowX0);
    localparam logic [W-1:0] WinY0 = W'(WindowY0);
    localparam logic [W-1:0] WinX1 = W'(WindowX0 + mapperPkg::WindowW);
    localparam logic [W-1:0] WinY1 = W'(WindowY0 + mapperPkg::WindowH);

    logic                  inWindow;
    logic [W-1:0]          relX;
    logic [W-1:0]          relY;
    logic [W-1:0]          mapX;
    logic [W-1:0]          mapY;
    logic [W-1:0]          dx;
    logic [W-1:0]          dy;
    mapperPkg::fetchWord   fetchNext;

    // ----------------------------------------
    // window test and map coordinate
    // ----------------------------------------
    assign inWindow = (drawPos.x >= WinX0) && (drawPos.x < WinX1) &&
                      (drawPos.y >= WinY0) && (drawPos.y < WinY1);

    assign relX = drawPos.x - WinX0;
    assign relY = drawPos.y - WinY0;

    // two screen pixels per map pixel
    assign mapX = {1'b0, relX[W-1:1]} + view.camera.x;
    assign mapY = {1'b0, relY[W-1:1]} + view.camera.y;

    // ----------------------------------------
    // sprite box, offset to its top-left
    // ----------------------------------------
    // wraps high when left of or above the box
    assign dx = drawPos.x - view.sprite.x + mapperPkg::SpriteHalfW;
    assign dy = drawPos.y - view.sprite.y + mapperPkg::SpriteHalfH;

    always_comb begin
        fetchNext.visible     = blank && inWindow;
        // tile column plus tile row, low bits only
        fetchNext.mapIndex    = mapX[TS +: IW] + mapY[TS +: IW];
        fetchNext.spriteHit   = (dx < mapperPkg::SpriteW) && (dy < mapperPkg::SpriteH);
        // zero here reads as transparent downstream
        fetchNext.spriteIndex = dx[IW-1:0] + dy[IW-1:0];
    end

    // stage one
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            fetch <= '0;
        end
        else begin
            fetch <= fetchNext;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixelComposer.sv */
`default_nettype none

module pixelComposer (
    input  logic                clk,
    input  logic                Reset,
    input  mapperPkg::fetchWord fetch,
    output mapperPkg::rgbPixel  pixel
);

    localparam int PadWidth = mapperPkg::ColorWidth - mapperPkg::IndexWidth;

    mapperPkg::rgbPixel mapColor;
    mapperPkg::rgbPixel spriteColor;
    mapperPkg::rgbPixel pixelNext;
    logic               spriteShown;

    // ----------------------------------------
    // palettes
    // ----------------------------------------
    // map ramps red up and green down with the index
    always_comb begin
        mapColor.red   = {fetch.mapIndex, {PadWidth{1'b0}}};
        mapColor.green = {~fetch.mapIndex, {PadWidth{1'b0}}};
        mapColor.blue  = mapperPkg::MapBlue;
    end

    // sprite is red with a green ramp
    always_comb begin
        spriteColor.red   = mapperPkg::SpriteRed;
        spriteColor.green = {fetch.spriteIndex, {PadWidth{1'b0}}};
        spriteColor.blue  = mapperPkg::SpriteBlue;
    end

    // index zero lets the map through
    assign spriteShown = fetch.spriteHit && (fetch.spriteIndex != '0);

    always_comb begin
        if (!fetch.visible) begin
            pixelNext = '0;
        end
        else if (spriteShown) begin
            pixelNext = spriteColor;
        end
        else begin
            pixelNext = mapColor;
        end
    end

    // stage two
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            pixel <= '0;
        end
        else begin
            pixel <= pixelNext;
        end
    end

endmodule

`default_nettype wire

/* hdl/colorMapper.sv */
`default_nettype none

module colorMapper #(
    parameter int CameraXMax = 240,
    parameter int CameraYMax = 160,
    parameter int WindowX0   = 80,
    parameter int WindowY0   = 80
) (
    input  logic                             clk,
    input  logic                             Reset,
    input  logic [mapperPkg::CoordWidth-1:0] drawX,
    input  logic [mapperPkg::CoordWidth-1:0] drawY,
    input  logic                             blank,
    input  logic                             frameStart,
    input  logic [mapperPkg::KeyWidth-1:0]   keycode,
    output logic [mapperPkg::ColorWidth-1:0] red,
    output logic [mapperPkg::ColorWidth-1:0] green,
    output logic [mapperPkg::ColorWidth-1:0] blue
);

    mapperPkg::moveCmd   move;
    mapperPkg::viewState view;
    mapperPkg::pixelPos  drawPos;
    mapperPkg::fetchWord fetch;
    mapperPkg::rgbPixel  pixel;

    assign drawPos.x = drawX;
    assign drawPos.y = drawY;

    // ----------------------------------------
    // motion side
    // ----------------------------------------
    keyDecoder u_keyDecoder (
        .keycode (keycode),
        .move    (move)
    );

    scrollControl #(
        .CameraXMax (CameraXMax),
        .CameraYMax (CameraYMax)
    ) u_scrollControl (
        .clk        (clk),
        .Reset      (Reset),
        .frameStart (frameStart),
        .move       (move),
        .view       (view)
    );

    // ----------------------------------------
    // pixel pipeline, two cycles
    // ----------------------------------------
    pixelFetch #(
        .WindowX0 (WindowX0),
        .WindowY0 (WindowY0)
    ) u_pixelFetch (
        .clk     (clk),
        .Reset   (Reset),
        .drawPos (drawPos),
        .blank   (blank),
        .view    (view),
        .fetch   (fetch)
    );

    pixelComposer u_pixelComposer (
        .clk   (clk),
        .Reset (Reset),
        .fetch (fetch),
        .pixel (pixel)
    );

    assign red   = pixel.red;
    assign green = pixel.green;
    assign blue  = pixel.blue;

endmodule

`default_nettype wire

/* verif/colorMapper_properties.sv */
`default_nettype none

module colorMapper_properties #(
    parameter int WindowX0 = 80,
    parameter int WindowY0 = 80
) (
    input logic       clk,
    input logic       Reset,
    input logic [9:0] drawX,
    input logic [9:0] drawY,
    input logic       blank,
    input logic       frameStart,
    input logic [7:0] red,
    input logic [7:0] green,
    input logic [7:0] blue
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failCount = 0;
    logic outside;

    assign outside = (int'(drawX) < WindowX0) || (int'(drawX) >= WindowX0 + 480) ||
                     (int'(drawY) < WindowY0) || (int'(drawY) >= WindowY0 + 320);

    resetBlack: assert property (@(posedge clk) Reset |-> {red, green, blue} == 24'h0)
        else begin $error("rgb not zero in reset"); failCount++; end

    // rgb for a pixel sampled at edge N is seen at edge N+2
    blankBlack: assert property (@(posedge clk) disable iff (Reset)
        !blank |-> ##2 {red, green, blue} == 24'h0)
        else begin $error("blanked pixel not black"); failCount++; end

    outsideBlack: assert property (@(posedge clk) disable iff (Reset)
        outside |-> ##2 {red, green, blue} == 24'h0)
        else begin $error("pixel outside window not black"); failCount++; end

    frameKnown: assert property (@(posedge clk) !$isunknown(frameStart))
        else begin $error("frameStart unknown"); failCount++; end

endmodule

bind colorMapper colorMapper_properties #(
    .WindowX0 (WindowX0),
    .WindowY0 (WindowY0)
) u_properties (
    .clk        (clk),
    .Reset      (Reset),
    .drawX      (drawX),
    .drawY      (drawY),
    .blank      (blank),
    .frameStart (frameStart),
    .red        (red),
    .green      (green),
    .blue       (blue)
);

`default_nettype wire

/* verif/mapperChecker.sv */
`default_nettype none

module mapperChecker #(
    parameter int WindowX0 = 80,
    parameter int WindowY0 = 80,
    parameter int CamXMax  = 240,
    parameter int CamYMax  = 160
) (
    input  logic        clk,
    input  logic        Reset,
    input  logic [9:0]  drawX,
    input  logic [9:0]  drawY,
    input  logic        blank,
    input  logic        frameStart,
    input  logic [15:0] keycode,
    input  logic [7:0]  red,
    input  logic [7:0]  green,
    input  logic [7:0]  blue,
    input  logic        testDone,
    input  logic [7:0]  testNum,
    output int          checkCount,
    output int          errorCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // model state
    int camX;
    int camY;
    int sprX;
    int sprY;
    int warm;
    logic [23:0] exp0;
    logic [23:0] exp1;
    int testChecks;
    int testErrors;

    function automatic int keyDx(input logic [7:0] k);
        if (k == 8'd4) return -1;
        if (k == 8'd7) return 1;
        return 0;
    endfunction

    function automatic int keyDy(input logic [7:0] k);
        if (k == 8'd26) return -1;
        if (k == 8'd22) return 1;
        return 0;
    endfunction

    // ----------------------------------------
    // position model
    // ----------------------------------------
    task automatic moveAxis(input int d, input int center, input int camMax,
                            input int sMin, input int sMax, inout int cam, inout int spr);
        if (d != 0) begin
            if (spr == center && cam + d >= 0 && cam + d <= camMax) begin
                cam = cam + d;
            end
            else if (spr + d >= sMin && spr + d <= sMax) begin
                spr = spr + d;
            end
        end
    endtask

    task automatic applyFrame(input logic [15:0] code);
        logic [7:0] hi;
        logic [7:0] lo;
        int sx;
        int sy;
        hi = code[15:8];
        lo = code[7:0];
        sx = 0;
        sy = 0;
        if (hi == 8'd0) begin
            sx = keyDx(lo);
            sy = keyDy(lo);
        end
        else if (keyDx(lo) != 0 && keyDy(hi) != 0) begin
            sx = keyDx(lo);
            sy = keyDy(hi);
        end
        else if (keyDy(lo) != 0 && keyDx(hi) != 0) begin
            sx = keyDx(hi);
            sy = keyDy(lo);
        end
        moveAxis(sx, 320, CamXMax, 100, 539, camX, sprX);
        moveAxis(sy, 240, CamYMax, 100, 379, camY, sprY);
    endtask

    // expected colour of one pixel
    function automatic logic [23:0] predict(input int x, input int y, input logic b);
        int mx;
        int my;
        int mi;
        int dx;
        int dy;
        int si;
        logic vis;
        vis = b && x >= WindowX0 && x < WindowX0 + 480 && y >= WindowY0 && y < WindowY0 + 320;
        mx  = (x - WindowX0) / 2 + camX;
        my  = (y - WindowY0) / 2 + camY;
        mi  = (mx / 16 + my / 16) % 16;
        dx  = x - sprX + 7;
        dy  = y - sprY + 10;
        si  = (dx + dy) % 16;
        if (!vis) return 24'h0;
        if (dx >= 0 && dx <= 13 && dy >= 0 && dy <= 19 && si != 0) begin
            return {8'd255, 8'(si * 16), 8'd0};
        end
        return {8'(mi * 16), 8'((15 - mi) * 16), 8'd128};
    endfunction

    // prediction uses the state before this edge's frame update
    always @(posedge clk) begin
        if (Reset) begin
            camX = 0;
            camY = 0;
            sprX = 320;
            sprY = 240;
            warm = 0;
        end
        else begin
            // exp1 lines up with the rgb register
            exp1 = exp0;
            exp0 = predict(int'(drawX), int'(drawY), blank);
            if (warm < 2) warm = warm + 1;
            if (frameStart) applyFrame(keycode);
        end
    end

    // ----------------------------------------
    // compare and report
    // ----------------------------------------
    task automatic compareChannel(input string name, input logic [7:0] expv,
                                  input logic [7:0] got);
        checkCount++;
        testChecks++;
        if (got !== expv) begin
            errorCount++;
            testErrors++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expv, got);
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
        testChecks = 0;
        testErrors = 0;
        warm       = 0;
    end

    // rgb is steady between rising edges
    always @(negedge clk) begin
        if (!Reset && warm >= 2) begin
            compareChannel("red", exp1[23:16], red);
            compareChannel("green", exp1[15:8], green);
            compareChannel("blue", exp1[7:0], blue);
        end
        if (testDone) begin
            $display("test %0d finished: %0d checks, %0d errors", testNum, testChecks,
                     testErrors);
            testChecks = 0;
            testErrors = 0;
        end
    end

endmodule

`default_nettype wire

/* verif/colorMapperTb.sv */
`default_nettype none

module colorMapperTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Period    = 40;
    localparam int StimDepth = 256;
    localparam int WinX0     = 80;
    localparam int WinY0     = 80;

    logic        clk;
    logic        Reset;
    logic        blank;
    logic        frameStart;
    logic        testDone;
    logic [7:0]  testNum;
    logic [9:0]  drawX;
    logic [9:0]  drawY;
    logic [15:0] keycode;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [15:0] stim [0:StimDepth-1];
    logic [31:0] rngState;
    int          checkCount;
    int          errorCount;
    int          budget;
    logic        budgetReady;

    always #(Period / 2) clk = ~clk;

    colorMapper #(
        .CameraXMax (240),
        .CameraYMax (160),
        .WindowX0   (WinX0),
        .WindowY0   (WinY0)
    ) u_colorMapper (
        .clk        (clk),
        .Reset      (Reset),
        .drawX      (drawX),
        .drawY      (drawY),
        .blank      (blank),
        .frameStart (frameStart),
        .keycode    (keycode),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    mapperChecker #(
        .WindowX0 (WinX0),
        .WindowY0 (WinY0),
        .CamXMax  (240),
        .CamYMax  (160)
    ) u_checker (
        .clk        (clk),
        .Reset      (Reset),
        .drawX      (drawX),
        .drawY      (drawY),
        .blank      (blank),
        .frameStart (frameStart),
        .keycode    (keycode),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .testDone   (testDone),
        .testNum    (testNum),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // one clock of drive values
    task automatic driveCycle(input logic fs, input logic [15:0] key, input logic b,
                              input logic [9:0] x, input logic [9:0] y);
        @(posedge clk);
        frameStart <= fs;
        keycode    <= key;
        blank      <= b;
        drawX      <= x;
        drawY      <= y;
    endtask

    // visible pixel somewhere inside the window
    task automatic randomCycle(input logic fs, input logic [15:0] key);
        logic [9:0] x;
        logic [9:0] y;
        rngState = xorshift(rngState);
        x = 10'(WinX0 + int'(rngState % 480));
        rngState = xorshift(rngState);
        y = 10'(WinY0 + int'(rngState % 320));
        driveCycle(fs, key, 1'b1, x, y);
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        wait (budgetReady);
        #(budget * Period);
        $display("timeout: stimulus did not finish within %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int pc;
        int n;
        int propFails;
        clk         = 1'b0;
        Reset       = 1'b1;
        blank       = 1'b0;
        frameStart  = 1'b0;
        testDone    = 1'b0;
        testNum     = 8'd0;
        drawX       = '0;
        drawY       = '0;
        keycode     = '0;
        rngState    = 32'd82;
        budget      = 50;
        budgetReady = 1'b0;
        $readmemh("verif/mapper_stim.txt", stim);

        // cycle budget, records are four words
        pc = 0;
        while (stim[pc] !== 16'h0 && pc < StimDepth - 4) begin
            case (stim[pc])
                16'h1: budget += 4 * int'(stim[pc+2]);
                16'h3: budget += int'(stim[pc+1]);
                default: budget += 6;
            endcase
            pc += 4;
        end
        budget      = 2 * budget;
        budgetReady = 1'b1;

        repeat (3) @(posedge clk);
        Reset <= 1'b0;

        pc = 0;
        while (stim[pc] !== 16'h0 && pc < StimDepth - 4) begin
            case (stim[pc])
                // keycode held for a number of frames
                16'h1: begin
                    for (n = 0; n < int'(stim[pc+2]); n++) begin
                        randomCycle(1'b1, stim[pc+1]);
                        repeat (3) randomCycle(1'b0, stim[pc+1]);
                    end
                end
                // one probe pixel, blank level first
                16'h2: driveCycle(1'b0, 16'h0, stim[pc+1][0], stim[pc+2][9:0],
                                  stim[pc+3][9:0]);
                16'h3: begin
                    for (n = 0; n < int'(stim[pc+1]); n++) begin
                        randomCycle(1'b0, 16'h0);
                    end
                end
                // drain pipeline then close the test
                16'h4: begin
                    repeat (3) driveCycle(1'b0, 16'h0, 1'b0, '0, '0);
                    @(posedge clk);
                    testDone <= 1'b1;
                    testNum  <= stim[pc+1][7:0];
                    @(posedge clk);
                    testDone <= 1'b0;
                end
                default: $display("unknown stimulus command at word %0d", pc);
            endcase
            pc += 4;
        end

        repeat (3) @(posedge clk);
        propFails = u_colorMapper.u_properties.failCount;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, propFails);
        if (errorCount == 0 && propFails == 0 && checkCount > 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mapper_stim.txt */
// hex words, four per record: op arg0 arg1 arg2
// op 1 frames(key count), 2 probe(blank x y), 3 random(count), 4 end test(num), 0 stop
2 1 140 F0
2 1 140 EF
2 1 50 50
2 1 20F 18F
4 1 0 0
1 7 14 0
1 16 0A 0
2 1 140 F0
2 1 13A E6
2 1 100 100
4 2 0 0
1 4 FA 0
2 1 64 F0
2 1 5D E6
1 7 E6 0
2 1 140 F0
2 1 139 EF
4 3 0 0
1 1A07 5 0
1 716 5 0
1 41A 3 0
1 407 5 0
1 99 5 0
2 1 140 F0
4 4 0 0
2 0 140 F0
2 0 100 100
2 1 A A
2 1 258 C8
2 1 12C 190
3 C8 0 0
4 5 0 0
0 0 0 0

/* files.f */
hdl/mapperPkg.sv
hdl/keyDecoder.sv
hdl/scrollControl.sv
hdl/pixelFetch.sv
hdl/pixelComposer.sv
hdl/colorMapper.sv
verif/colorMapper_properties.sv
verif/mapperChecker.sv
verif/colorMapperTb.sv

/* run.sh */
#!/bin/sh
# build, run, and judge the simulation log
verilator --binary --assert --top-module colorMapperTb -f files.f -o simv \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
